//--- Makefile
# Verilator build and run of the peripheral subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_periph_system
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+.
periph_pkg.sv
periph_xbar.sv
gpio_regs.sv
timer_regs.sv
periph_system.sv
tb_periph_system.sv

//--- gpio_regs.sv
/*
 * GPIO register block.
 * Byte-writable output register and synchronized inputs.
 */
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module gpio_regs import periph_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        arst_n_i,

  input  dev_req_t    dev_req_i,
  output periph_rsp_t dev_rsp_o,

  input  gpi_t        gp_i,
  output gpo_t        gp_o
);

  gpi_t  gpi_sync_q [`GPIO_SYNC_STAGES];
  gpo_t  gpo_q;
  gpo_t  gpo_d;
  logic  hit_gpo;
  logic  hit_gpi;
  logic  gpo_we;
  logic  rvalid_q;
  logic  err_q;
  data_t rdata_d;
  data_t rdata_q;

  assign hit_gpo = (dev_req_i.addr == `GPIO_GPO_OFS);
  assign hit_gpi = (dev_req_i.addr == `GPIO_GPI_OFS);
  assign gpo_we  = dev_req_i.req & dev_req_i.we & hit_gpo;

  // Upper enable bits fall beyond the output width.
  assign gpo_d = gpo_t'(apply_be(data_t'(gpo_q), dev_req_i.wdata, dev_req_i.be));

  // Input synchronizer.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `GPIO_SYNC_STAGES; i++) begin
        gpi_sync_q[i] <= '0;
      end
    end else begin
      gpi_sync_q[0] <= gp_i;
      for (int i = 1; i < `GPIO_SYNC_STAGES; i++) begin
        gpi_sync_q[i] <= gpi_sync_q[i-1];
      end
    end
  end

  // Read data, zero for writes.
  always_comb begin
    rdata_d = '0;
    if (dev_req_i.req && !dev_req_i.we) begin
      if (hit_gpo) begin
        rdata_d = data_t'(gpo_q);
      end else if (hit_gpi) begin
        rdata_d = data_t'(gpi_sync_q[`GPIO_SYNC_STAGES-1]);
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpo_q    <= '0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      if (gpo_we) begin
        gpo_q <= gpo_d;
      end
      rvalid_q <= dev_req_i.req;
      err_q    <= dev_req_i.req & ~hit_gpo & ~hit_gpi;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= rdata_d;
  end

  assign gp_o             = gpo_q;
  assign dev_rsp_o.rvalid = rvalid_q;
  assign dev_rsp_o.rdata  = rdata_q;
  assign dev_rsp_o.err    = err_q;

  rvalid_follows_req_a: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    1'b1 |=> (dev_rsp_o.rvalid == $past(dev_req_i.req))
  );

endmodule

`default_nettype wire

//--- periph_params.svh
/*
 * Peripheral subsystem parameters.
 * Bus widths, the device map and the register offsets of each device.
 */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Host bus widths.
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_BE_W   4
`define PERIPH_REG_AW 8

// Device select field, addr[15:12].
`define PERIPH_DEV_LSB 12
`define PERIPH_DEV_W   4

// Mapped regions, everything else errors.
`define DEV_GPIO  4'd0
`define DEV_TIMER 4'd1

// GPIO.
`define GPI_W            8
`define GPO_W            16
`define GPIO_SYNC_STAGES 2
`define GPIO_GPO_OFS     8'h00
`define GPIO_GPI_OFS     8'h04

// Timer register map.
`define TIMER_MTIME_LO_OFS 8'h00
`define TIMER_MTIME_HI_OFS 8'h04
`define TIMER_CMP_LO_OFS   8'h08
`define TIMER_CMP_HI_OFS   8'h0C

`endif

//--- periph_pkg.sv
/*
 * Peripheral bus package.
 * Vector types, host and device request and response structs,
 * and the byte-enable merge shared by the register blocks.
 */
`default_nettype none
`include "periph_params.svh"

package periph_pkg;

  // Bus vectors.
  typedef logic [`PERIPH_ADDR_W-1:0]   addr_t;
  typedef logic [`PERIPH_DATA_W-1:0]   data_t;
  typedef logic [`PERIPH_BE_W-1:0]     be_t;
  typedef logic [`PERIPH_REG_AW-1:0]   reg_addr_t;
  typedef logic [`GPI_W-1:0]           gpi_t;
  typedef logic [`GPO_W-1:0]           gpo_t;
  typedef logic [2*`PERIPH_DATA_W-1:0] mtime_t;

  // Host request, valid in every cycle where req is high.
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } periph_req_t;

  // Response, one cycle after its request.
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } periph_rsp_t;

  // Request as seen by one device; addr is the register offset.
  typedef struct packed {
    logic      req;
    logic      we;
    be_t       be;
    reg_addr_t addr;
    data_t     wdata;
  } dev_req_t;

  // Replace the enabled bytes of a word.
  function automatic data_t apply_be(data_t old_w, data_t new_w, be_t be);
    data_t merged;
    merged = old_w;
    for (int i = 0; i < `PERIPH_BE_W; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- periph_system.sv
/*
 * Peripheral subsystem top.
 * One host bus split by the crossbar into GPIO and timer.
 */
`timescale 1ns/10ps
`default_nettype none

module periph_system import periph_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        arst_n_i,

  input  periph_req_t host_req_i,
  output periph_rsp_t host_rsp_o,

  input  gpi_t        gp_i,
  output gpo_t        gp_o,
  output logic        timer_irq_o
);

  // Device side of the crossbar.
  dev_req_t    gpio_req;
  periph_rsp_t gpio_rsp;
  dev_req_t    timer_req;
  periph_rsp_t timer_rsp;

  periph_xbar u_xbar (
    .clk_sys_i  (clk_sys_i),
    .arst_n_i   (arst_n_i),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp),
    .timer_req_o(timer_req),
    .timer_rsp_i(timer_rsp)
  );

  gpio_regs u_gpio (
    .clk_sys_i(clk_sys_i),
    .arst_n_i (arst_n_i),
    .dev_req_i(gpio_req),
    .dev_rsp_o(gpio_rsp),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i  (clk_sys_i),
    .arst_n_i   (arst_n_i),
    .dev_req_i  (timer_req),
    .dev_rsp_o  (timer_rsp),
    .timer_irq_o(timer_irq_o)
  );

endmodule

`default_nettype wire

//--- periph_xbar.sv
/*
 * Peripheral crossbar.
 * Decodes the host address into one device request and merges the
 * device responses; unmapped regions answer with an error.
 */
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module periph_xbar import periph_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        arst_n_i,

  input  periph_req_t host_req_i,
  output periph_rsp_t host_rsp_o,

  output dev_req_t    gpio_req_o,
  input  periph_rsp_t gpio_rsp_i,
  output dev_req_t    timer_req_o,
  input  periph_rsp_t timer_rsp_i
);

  logic [`PERIPH_DEV_W-1:0] dev_sel;
  logic                     sel_gpio;
  logic                     sel_timer;
  logic                     unmapped_q;
  dev_req_t                 dev_req;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign dev_sel   = host_req_i.addr[`PERIPH_DEV_LSB +: `PERIPH_DEV_W];
  assign sel_gpio  = (dev_sel == `DEV_GPIO);
  assign sel_timer = (dev_sel == `DEV_TIMER);

  // Payload common to both devices.
  always_comb begin
    dev_req.req   = 1'b0;
    dev_req.we    = host_req_i.we;
    dev_req.be    = host_req_i.be;
    dev_req.addr  = host_req_i.addr[`PERIPH_REG_AW-1:0];
    dev_req.wdata = host_req_i.wdata;
  end

  always_comb begin
    gpio_req_o      = dev_req;
    gpio_req_o.req  = host_req_i.req & sel_gpio;
    timer_req_o     = dev_req;
    timer_req_o.req = host_req_i.req & sel_timer;
  end

  // No device answers an unmapped access, so answer it here.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= host_req_i.req & ~sel_gpio & ~sel_timer;
    end
  end

  //////////////////////////////
  // Response merge
  //////////////////////////////

  always_comb begin
    host_rsp_o.rvalid = gpio_rsp_i.rvalid | timer_rsp_i.rvalid | unmapped_q;
    host_rsp_o.err    = unmapped_q
                      | (gpio_rsp_i.rvalid & gpio_rsp_i.err)
                      | (timer_rsp_i.rvalid & timer_rsp_i.err);
    if (gpio_rsp_i.rvalid) begin
      host_rsp_o.rdata = gpio_rsp_i.rdata;
    end else if (timer_rsp_i.rvalid) begin
      host_rsp_o.rdata = timer_rsp_i.rdata;
    end else begin
      // Unmapped or idle.
      host_rsp_o.rdata = '0;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  dev_req_onehot_a: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    !(gpio_req_o.req && timer_req_o.req)
  );

  // At most one source answers in a cycle, across both devices.
  rsp_onehot_a: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    $onehot0({gpio_rsp_i.rvalid, timer_rsp_i.rvalid, unmapped_q})
  );

endmodule

`default_nettype wire

//--- tb_periph_system.sv
/*
 * Testbench for the peripheral subsystem.
 * Random bus traffic checked against a cycle model of the GPIO outputs,
 * the timer counter, the compare value and the interrupt.
 */
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module tb_periph_system import periph_pkg::*; ();

  localparam int timeout_cycles = 16;
  localparam int dw             = `PERIPH_DATA_W;

  logic                     clk_sys_i;
  logic                     arst_n_i;
  periph_req_t              host_req;
  periph_rsp_t              host_rsp;
  periph_rsp_t              rsp_s;
  gpi_t                     gp_i;
  gpo_t                     gp_o;
  logic                     timer_irq;
  gpo_t                     model_gpo;
  mtime_t                   model_mtime;
  mtime_t                   model_cmp;
  logic                     model_irq;
  integer                   seed;
  data_t                    rnd;
  data_t                    v;
  data_t                    rdata;
  mtime_t                   target;
  logic [`PERIPH_DEV_W-1:0] region;
  int                       k;

  periph_system u_periph_system (
    .clk_sys_i  (clk_sys_i),
    .arst_n_i   (arst_n_i),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .gp_i       (gp_i),
    .gp_o       (gp_o),
    .timer_irq_o(timer_irq)
  );

  always #10 clk_sys_i = ~clk_sys_i;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic addr_t dev_addr(logic [`PERIPH_DEV_W-1:0] dev, reg_addr_t ofs);
    addr_t a;
    a = '0;
    a[`PERIPH_DEV_LSB +: `PERIPH_DEV_W] = dev;
    a[`PERIPH_REG_AW-1:0] = ofs;
    return a;
  endfunction

  // Each enable bit selects one byte lane of the new word.
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic write_hit(periph_req_t r, logic [`PERIPH_DEV_W-1:0] dev,
                                     reg_addr_t ofs);
    return r.req && r.we && (r.addr[`PERIPH_DEV_LSB +: `PERIPH_DEV_W] == dev)
           && (r.addr[`PERIPH_REG_AW-1:0] == ofs);
  endfunction

  // Counter counts unless one of its halves is written.
  function automatic mtime_t mtime_next(mtime_t cur, periph_req_t r);
    mtime_t nxt;
    nxt = cur + mtime_t'(1);
    if (write_hit(r, `DEV_TIMER, `TIMER_MTIME_LO_OFS)) begin
      nxt = {cur[2*dw-1:dw], merge_bytes(cur[dw-1:0], r.wdata, r.be)};
    end else if (write_hit(r, `DEV_TIMER, `TIMER_MTIME_HI_OFS)) begin
      nxt = {merge_bytes(cur[2*dw-1:dw], r.wdata, r.be), cur[dw-1:0]};
    end
    return nxt;
  endfunction

  function automatic mtime_t cmp_next(mtime_t cur, periph_req_t r);
    mtime_t nxt;
    nxt = cur;
    if (write_hit(r, `DEV_TIMER, `TIMER_CMP_LO_OFS)) begin
      nxt = {cur[2*dw-1:dw], merge_bytes(cur[dw-1:0], r.wdata, r.be)};
    end else if (write_hit(r, `DEV_TIMER, `TIMER_CMP_HI_OFS)) begin
      nxt = {merge_bytes(cur[2*dw-1:dw], r.wdata, r.be), cur[dw-1:0]};
    end
    return nxt;
  endfunction

  always @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      model_gpo   <= '0;
      model_mtime <= '0;
      model_cmp   <= '1;
      model_irq   <= 1'b0;
    end else begin
      model_irq   <= (model_mtime >= model_cmp);
      model_mtime <= mtime_next(model_mtime, host_req);
      model_cmp   <= cmp_next(model_cmp, host_req);
      if (write_hit(host_req, `DEV_GPIO, `GPIO_GPO_OFS)) begin
        model_gpo <= gpo_t'(merge_bytes(data_t'(model_gpo), host_req.wdata, host_req.be));
      end
    end
  end

  //////////////////////////////
  // Bus tasks and checks
  //////////////////////////////

  task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // Sample 1 ns after the edge and return at the drive point.
  task automatic tick();
    @(posedge clk_sys_i);
    #1;
    rsp_s = host_rsp;
    if (arst_n_i) begin
      check_value("timer_irq_o", 64'(timer_irq), 64'(model_irq));
      check_value("gp_o", 64'(gp_o), 64'(model_gpo));
    end
    #1;
  endtask

  task automatic bus_access(input logic we, input be_t be, input addr_t addr,
                            input data_t wdata, output data_t rd, output logic er);
    int waited;
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.be    = be;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    tick();
    host_req = '0;
    waited   = 0;
    while (!rsp_s.rvalid && waited < timeout_cycles) begin
      tick();
      waited++;
    end
    if (!rsp_s.rvalid) begin
      $display("No response on the host bus within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $fatal(1);
    end else begin
      check_value("rvalid latency", 64'(waited), 64'(0));
      rd = rsp_s.rdata;
      er = rsp_s.err;
    end
  endtask

  task automatic reg_write(addr_t addr, be_t be, data_t wdata);
    data_t rd;
    logic  er;
    bus_access(1'b1, be, addr, wdata, rd, er);
    check_value("err", 64'(er), 64'(0));
    check_value("rdata", 64'(rd), 64'(0));
  endtask

  task automatic reg_read(input addr_t addr, output data_t rd);
    logic er;
    bus_access(1'b0, 4'hF, addr, '0, rd, er);
    check_value("err", 64'(er), 64'(0));
  endtask

  task automatic expect_error(logic we, addr_t addr);
    data_t rd;
    logic  er;
    bus_access(we, 4'hF, addr, $random(seed), rd, er);
    check_value("err", 64'(er), 64'(1));
    check_value("rdata", 64'(rd), 64'(0));
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    seed      = 73378;
    clk_sys_i = 1'b0;
    arst_n_i  = 1'b0;
    host_req  = '0;
    gp_i      = '0;
    repeat (8) @(posedge clk_sys_i);
    #2;
    arst_n_i = 1'b1;

    // Reset values, idle bus.
    check_value("gp_o", 64'(gp_o), 64'(0));
    check_value("timer_irq_o", 64'(timer_irq), 64'(0));
    repeat (5) begin
      tick();
      check_value("rvalid", 64'(rsp_s.rvalid), 64'(0));
    end

    // GPO writes with random byte enables.
    repeat (20) begin
      rnd = $random(seed);
      v   = $random(seed);
      reg_write(dev_addr(`DEV_GPIO, `GPIO_GPO_OFS), rnd[3:0], v);
      reg_read(dev_addr(`DEV_GPIO, `GPIO_GPO_OFS), rdata);
      check_value("rdata", 64'(rdata), 64'(model_gpo));
    end

    // Synchronized inputs.
    repeat (10) begin
      rnd  = $random(seed);
      gp_i = rnd[`GPI_W-1:0];
      repeat (4) tick();
      reg_read(dev_addr(`DEV_GPIO, `GPIO_GPI_OFS), rdata);
      check_value("rdata", 64'(rdata), 64'(rnd[`GPI_W-1:0]));
    end

    // Counter low half counts from the written value.
    repeat (8) begin
      v   = $random(seed);
      rnd = $random(seed);
      k   = int'(rnd[3:0]);
      reg_write(dev_addr(`DEV_TIMER, `TIMER_MTIME_LO_OFS), 4'hF, v);
      repeat (k) tick();
      reg_read(dev_addr(`DEV_TIMER, `TIMER_MTIME_LO_OFS), rdata);
      check_value("mtime_lo", 64'(rdata), 64'(data_t'(v + data_t'(k))));
    end

    // Carry into the high half.
    v = $random(seed);
    reg_write(dev_addr(`DEV_TIMER, `TIMER_MTIME_LO_OFS), 4'hF, 32'h0);
    reg_write(dev_addr(`DEV_TIMER, `TIMER_MTIME_HI_OFS), 4'hF, v);
    reg_write(dev_addr(`DEV_TIMER, `TIMER_MTIME_LO_OFS), 4'hF, 32'hFFFF_FFF8);
    repeat (12) tick();
    reg_read(dev_addr(`DEV_TIMER, `TIMER_MTIME_HI_OFS), rdata);
    check_value("mtime_hi", 64'(rdata), 64'(data_t'(v + 32'd1)));

    // Compare a random distance ahead; tick() follows the interrupt.
    rnd    = $random(seed);
    target = model_mtime + mtime_t'(rnd[4:0]) + mtime_t'(6);
    reg_write(dev_addr(`DEV_TIMER, `TIMER_CMP_HI_OFS), 4'hF, target[2*dw-1:dw]);
    reg_write(dev_addr(`DEV_TIMER, `TIMER_CMP_LO_OFS), 4'hF, target[dw-1:0]);
    repeat (48) tick();
    check_value("timer_irq_o", 64'(timer_irq), 64'(1));
    reg_write(dev_addr(`DEV_TIMER, `TIMER_CMP_HI_OFS), 4'hF, 32'hFFFF_FFFF);
    repeat (2) tick();
    check_value("timer_irq_o", 64'(timer_irq), 64'(0));

    // Unmapped regions and unknown offsets.
    repeat (8) begin
      rnd    = $random(seed);
      region = rnd[3:0] | 4'h2;
      expect_error(rnd[12], dev_addr(region, rnd[11:4]));
    end
    expect_error(1'b0, dev_addr(`DEV_GPIO, 8'h08));
    expect_error(1'b1, dev_addr(`DEV_GPIO, 8'h08));
    expect_error(1'b0, dev_addr(`DEV_TIMER, 8'h10));
    expect_error(1'b1, dev_addr(`DEV_TIMER, 8'h10));
    reg_write(dev_addr(`DEV_GPIO, `GPIO_GPI_OFS), 4'hF, $random(seed));

    // Nothing changed by the errors.
    reg_read(dev_addr(`DEV_GPIO, `GPIO_GPO_OFS), rdata);
    check_value("gpo readback", 64'(rdata), 64'(model_gpo));
    reg_read(dev_addr(`DEV_TIMER, `TIMER_CMP_LO_OFS), rdata);
    check_value("cmp_lo", 64'(rdata), 64'(model_cmp[dw-1:0]));
    reg_read(dev_addr(`DEV_TIMER, `TIMER_CMP_HI_OFS), rdata);
    check_value("cmp_hi", 64'(rdata), 64'(model_cmp[2*dw-1:dw]));

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- timer_regs.sv
/*
 * Machine timer.
 * Free-running 64-bit counter, 64-bit compare value and a registered
 * interrupt, each half accessible as a 32-bit register.
 */
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module timer_regs import periph_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        arst_n_i,

  input  dev_req_t    dev_req_i,
  output periph_rsp_t dev_rsp_o,

  output logic        timer_irq_o
);

  mtime_t mtime_q;
  mtime_t mtime_d;
  mtime_t mtimecmp_q;
  mtime_t mtimecmp_d;
  data_t  mtime_lo;
  data_t  mtime_hi;
  data_t  cmp_lo;
  data_t  cmp_hi;
  logic   wr_en;
  logic   ofs_ok;
  logic   irq_q;
  logic   rvalid_q;
  logic   err_q;
  data_t  rdata_d;
  data_t  rdata_q;

  assign mtime_lo = mtime_q[`PERIPH_DATA_W-1:0];
  assign mtime_hi = mtime_q[2*`PERIPH_DATA_W-1:`PERIPH_DATA_W];
  assign cmp_lo   = mtimecmp_q[`PERIPH_DATA_W-1:0];
  assign cmp_hi   = mtimecmp_q[2*`PERIPH_DATA_W-1:`PERIPH_DATA_W];
  assign wr_en    = dev_req_i.req & dev_req_i.we;

  //////////////////////////////
  // Register decode
  //////////////////////////////

  always_comb begin
    mtime_d    = mtime_q + mtime_t'(1);
    mtimecmp_d = mtimecmp_q;
    rdata_d    = '0;
    ofs_ok     = 1'b1;
    case (dev_req_i.addr)
      `TIMER_MTIME_LO_OFS: begin
        // A counter write holds off the increment.
        if (wr_en) begin
          mtime_d = {mtime_hi, apply_be(mtime_lo, dev_req_i.wdata, dev_req_i.be)};
        end
        rdata_d = mtime_lo;
      end
      `TIMER_MTIME_HI_OFS: begin
        if (wr_en) begin
          mtime_d = {apply_be(mtime_hi, dev_req_i.wdata, dev_req_i.be), mtime_lo};
        end
        rdata_d = mtime_hi;
      end
      `TIMER_CMP_LO_OFS: begin
        if (wr_en) begin
          mtimecmp_d = {cmp_hi, apply_be(cmp_lo, dev_req_i.wdata, dev_req_i.be)};
        end
        rdata_d = cmp_lo;
      end
      `TIMER_CMP_HI_OFS: begin
        if (wr_en) begin
          mtimecmp_d = {apply_be(cmp_hi, dev_req_i.wdata, dev_req_i.be), cmp_lo};
        end
        rdata_d = cmp_hi;
      end
      default: begin
        ofs_ok = 1'b0;
      end
    endcase
    // Reads only; writes and errors return zero.
    if (!dev_req_i.req || dev_req_i.we) begin
      rdata_d = '0;
    end
  end

  //////////////////////////////
  // State
  //////////////////////////////

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
      rvalid_q   <= dev_req_i.req;
      err_q      <= dev_req_i.req & ~ofs_ok;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= rdata_d;
  end

  assign timer_irq_o      = irq_q;
  assign dev_rsp_o.rvalid = rvalid_q;
  assign dev_rsp_o.rdata  = rdata_q;
  assign dev_rsp_o.err    = err_q;

  rvalid_follows_req_a: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    1'b1 |=> (dev_rsp_o.rvalid == $past(dev_req_i.req))
  );

  irq_low_below_cmp_a: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    (mtime_q < mtimecmp_q) |=> !timer_irq_o
  );

endmodule

`default_nettype wire
